/* vlog.f */
+incdir+rtl
rtl/psr_arch_pkg.sv
rtl/psr_exc_pkg.sv
rtl/psr_if.sv
rtl/psr_flag_unit.sv
rtl/psr_cond_eval.sv
rtl/psr_mode_unit.sv
rtl/psr_top.sv
tb/psr_checker.sv
tb/psr_tb.sv

/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert
TOP       = psr_tb
FILELIST  = vlog.f
LOG       = sim.log
FAIL_MSG  = Some tests failed

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

/* tb/psr_tb.sv */
/* directed testbench for the status block, inputs change on the falling edge
   operand words and flag patterns come from an LCG with a fixed seed */
`timescale 1ns/1ns
`include "psr_params.svh"

module psr_tb;

   logic                   hclk, hreset_n, hready_i;
   logic [`PSR_WORD_W-1:0] alu_res_i, shift_res_i, psr_wdata_i;
   logic                   alu_cflag_i, alu_vflag_i, shift_nflag_i, shift_zflag_i;
   logic                   shift_cflag_i, shift_sel_i, nz_en_i, c_en_i, v_en_i;
   logic                   msr_en_i, xpsr_load_i, cps_en_i, cps_disable_i;
   logic [1:0]             msr_sel_i;
   logic [3:0]             cond_i;
   logic                   int_taken_i, exc_return_i, exc_return_psp_i, svc_escalate_i;
   logic [`PSR_IPSR_W-1:0] int_num_i;
   logic [`PSR_WORD_W-1:0] gpr_wdata_o;
   logic [3:0]             apsr_o;            // {N,Z,C,V}
   logic [`PSR_IPSR_W-1:0] ipsr_o;
   logic                   cc_pass_o, primask_o, primask_ex_o, control_o, sp_psp_o;
   logic                   handler_o, nmi_active_o, hardfault_active_o, svc_is_undef_o;

   int                     mismatches, timeouts;
   logic [31:0]            lcg_state;

   psr_top dut0 (.*);

   always #20 hclk = ~hclk;  // 40 ns period

   // --------------------
   // helpers
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // architectural Bcc table, f is {N,Z,C,V}
   function automatic logic cond_expect(input logic [3:0] code, input logic [3:0] f);
      logic n, z, c, v;
      {n, z, c, v} = f;
      case (code)
         psr_exc_pkg::CC_EQ: return z;
         psr_exc_pkg::CC_NE: return !z;
         psr_exc_pkg::CC_CS: return c;
         psr_exc_pkg::CC_CC: return !c;
         psr_exc_pkg::CC_MI: return n;
         psr_exc_pkg::CC_PL: return !n;
         psr_exc_pkg::CC_VS: return v;
         psr_exc_pkg::CC_VC: return !v;
         psr_exc_pkg::CC_HI: return c && !z;
         psr_exc_pkg::CC_LS: return !c || z;
         psr_exc_pkg::CC_GE: return n == v;
         psr_exc_pkg::CC_LT: return n != v;
         psr_exc_pkg::CC_GT: return !z && (n == v);
         psr_exc_pkg::CC_LE: return z || (n != v);
         default:            return 1'b0;
      endcase
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
      mismatches++;
      $display("MISMATCH %s got %h expected %h at %0t", name, got, expected, $time);
   endtask

   task automatic idle();  // all strobes low, both units idle
      hready_i         = 1'b1;
      alu_res_i        = '0;
      shift_res_i      = '0;
      psr_wdata_i      = '0;
      alu_cflag_i      = 1'b0;
      alu_vflag_i      = 1'b0;
      shift_nflag_i    = 1'b0;
      shift_zflag_i    = 1'b0;
      shift_cflag_i    = 1'b0;
      shift_sel_i      = 1'b0;
      nz_en_i          = 1'b0;
      c_en_i           = 1'b0;
      v_en_i           = 1'b0;
      msr_en_i         = 1'b0;
      msr_sel_i        = 2'd0;
      xpsr_load_i      = 1'b0;
      cond_i           = 4'd0;
      cps_en_i         = 1'b0;
      cps_disable_i    = 1'b0;
      int_taken_i      = 1'b0;
      int_num_i        = '0;
      exc_return_i     = 1'b0;
      exc_return_psp_i = 1'b0;
      svc_escalate_i   = 1'b0;
   endtask

   task automatic next_cycle();  // edge passed, drop strobes, let outputs settle
      @(negedge hclk);
      idle();
      #5;
   endtask

   task automatic drive_exec(input logic [3:0] f);  // shifter N,Z,C plus alu V
      shift_sel_i   = 1'b1;
      shift_nflag_i = f[3];
      shift_zflag_i = f[2];
      shift_cflag_i = f[1];
      alu_vflag_i   = f[0];
      nz_en_i       = 1'b1;
      c_en_i        = 1'b1;
      v_en_i        = 1'b1;
   endtask

   task automatic write_msr(input logic [1:0] sel, input logic [31:0] w);
      @(negedge hclk);
      msr_en_i    = 1'b1;
      msr_sel_i   = sel;
      psr_wdata_i = w;
      next_cycle();
   endtask

   task automatic set_primask(input logic pm);  // through CPS
      @(negedge hclk);
      cps_en_i      = 1'b1;
      cps_disable_i = pm;
      next_cycle();
   endtask

   task automatic wait_ipsr(input logic [`PSR_IPSR_W-1:0] num);
      int n;
      n = 0;
      while (ipsr_o !== num && n < 8) begin
         @(negedge hclk);
         #5;
         n++;
      end
      if (ipsr_o !== num) begin
         timeouts++;
         $display("timeout: exception number never reached %h", num);
      end
   endtask

   task automatic take_exception(input logic [`PSR_IPSR_W-1:0] num);
      @(negedge hclk);
      int_taken_i = 1'b1;
      int_num_i   = num;
      next_cycle();
      wait_ipsr(num);
   endtask

   task automatic sweep_codes(input logic [3:0] f);  // codes 0 to 13, one per cycle
      for (int c = 0; c < 14; c++) begin
         @(negedge hclk);
         cond_i = 4'(c);
         #5;
         if (cc_pass_o !== cond_expect(4'(c), f))
            report_mismatch("cc_pass_o", 32'(cc_pass_o), 32'(cond_expect(4'(c), f)));
      end
   endtask

   // --------------------
   // directed tests
   task automatic test_reset();
      if (ipsr_o !== psr_exc_pkg::EXC_HARDFAULT)
         report_mismatch("ipsr_o", 32'(ipsr_o), 32'h3);
      if (apsr_o !== 4'b1100) report_mismatch("apsr_o", 32'(apsr_o), 32'hc);
      if (hardfault_active_o !== 1'b1)
         report_mismatch("hardfault_active_o", 32'(hardfault_active_o), 32'h1);
      if (handler_o !== 1'b1) report_mismatch("handler_o", 32'(handler_o), 32'h1);
      if (primask_o !== 1'b0) report_mismatch("primask_o", 32'(primask_o), 32'h0);
      if (control_o !== 1'b0) report_mismatch("control_o", 32'(control_o), 32'h0);
   endtask

   task automatic test_merge_flags();
      logic [31:0] r, s;
      logic [3:0]  exp_f;
      logic        n, z, c;
      for (int i = 0; i < 24; i++) begin
         r = lcg_next();
         s = lcg_next();
         if (s[7:6] == 2'b00) r = '0;  // reach the Z flag now and then
         @(negedge hclk);
         alu_res_i     = s[0] ? r : '0;  // the other unit sits idle at zero
         shift_res_i   = s[0] ? '0 : r;
         alu_cflag_i   = s[1];
         alu_vflag_i   = s[2];
         shift_nflag_i = s[3];
         shift_zflag_i = s[4];
         shift_cflag_i = s[5];
         shift_sel_i   = s[8];
         nz_en_i       = s[9];
         c_en_i        = s[10];
         v_en_i        = s[11];
         hready_i      = s[12] | s[13];  // low one time in four
         n = s[8] ? s[3] : r[31];
         z = s[8] ? s[4] : (r == '0);
         c = s[8] ? s[5] : s[1];
         exp_f = apsr_o;
         if (hready_i && s[9]) exp_f[3:2] = {n, z};
         if (hready_i && s[10]) exp_f[1] = c;
         if (hready_i && s[11]) exp_f[0] = s[2];
         #5;
         if (gpr_wdata_o !== r) report_mismatch("gpr_wdata_o", gpr_wdata_o, r);
         next_cycle();
         if (apsr_o !== exp_f) report_mismatch("apsr_o", 32'(apsr_o), 32'(exp_f));
      end
   endtask

   task automatic test_msr_load();
      logic [31:0] w;
      w = lcg_next();
      @(negedge hclk);
      msr_en_i    = 1'b1;
      msr_sel_i   = psr_exc_pkg::SYSM_APSR;
      psr_wdata_i = w;
      drive_exec(~w[31:28]);  // execute flags must lose
      next_cycle();
      if (apsr_o !== w[31:28]) report_mismatch("apsr_o", 32'(apsr_o), 32'(w[31:28]));
      w = lcg_next();
      @(negedge hclk);
      xpsr_load_i = 1'b1;
      psr_wdata_i = w;
      drive_exec(~w[31:28]);
      next_cycle();
      if (apsr_o !== w[31:28]) report_mismatch("apsr_o", 32'(apsr_o), 32'(w[31:28]));
      if (ipsr_o !== w[5:0]) report_mismatch("ipsr_o", 32'(ipsr_o), 32'(w[5:0]));
   endtask

   task automatic test_cond_pass();
      logic [31:0] w;
      for (int k = 0; k < 6; k++) begin
         w = lcg_next();
         write_msr(psr_exc_pkg::SYSM_APSR, w);
         sweep_codes(w[31:28]);   // registered flags
         @(negedge hclk);
         hready_i = 1'b0;         // registers hold, execute flags forward
         drive_exec(w[27:24]);
         sweep_codes(w[27:24]);
         next_cycle();
      end
   endtask

   task automatic test_exceptions();
      @(negedge hclk);
      xpsr_load_i = 1'b1;
      psr_wdata_i = lcg_next() & 32'hffff_ffc0;  // back to thread
      next_cycle();
      if (handler_o !== 1'b0) report_mismatch("handler_o", 32'(handler_o), 32'h0);
      write_msr(psr_exc_pkg::SYSM_CONTROL, 32'h2);
      if (control_o !== 1'b1) report_mismatch("control_o", 32'(control_o), 32'h1);
      if (sp_psp_o !== 1'b1) report_mismatch("sp_psp_o", 32'(sp_psp_o), 32'h1);
      take_exception(psr_exc_pkg::EXC_NMI);
      if (nmi_active_o !== 1'b1) report_mismatch("nmi_active_o", 32'(nmi_active_o), 32'h1);
      if (hardfault_active_o !== 1'b0)
         report_mismatch("hardfault_active_o", 32'(hardfault_active_o), 32'h0);
      if (control_o !== 1'b0) report_mismatch("control_o", 32'(control_o), 32'h0);
      if (sp_psp_o !== 1'b0) report_mismatch("sp_psp_o", 32'(sp_psp_o), 32'h0);
      take_exception(psr_exc_pkg::EXC_HARDFAULT);
      if (nmi_active_o !== 1'b0) report_mismatch("nmi_active_o", 32'(nmi_active_o), 32'h0);
      if (hardfault_active_o !== 1'b1)
         report_mismatch("hardfault_active_o", 32'(hardfault_active_o), 32'h1);
      take_exception(psr_exc_pkg::EXC_SVCALL);
      write_msr(psr_exc_pkg::SYSM_CONTROL, 32'h2);  // handler mode, ignored
      if (control_o !== 1'b0) report_mismatch("control_o", 32'(control_o), 32'h0);
      @(negedge hclk);
      exc_return_i     = 1'b1;
      exc_return_psp_i = 1'b1;
      #5;
      if (sp_psp_o !== 1'b1) report_mismatch("sp_psp_o", 32'(sp_psp_o), 32'h1);
      next_cycle();
      if (control_o !== 1'b1) report_mismatch("control_o", 32'(control_o), 32'h1);
      if (sp_psp_o !== 1'b1) report_mismatch("sp_psp_o", 32'(sp_psp_o), 32'h1);
   endtask

   task automatic test_primask_svc();
      logic [`PSR_IPSR_W-1:0] nums [5];
      logic                   exp_u;
      nums = '{psr_exc_pkg::EXC_THREAD, psr_exc_pkg::EXC_NMI, psr_exc_pkg::EXC_HARDFAULT,
               psr_exc_pkg::EXC_SVCALL, 6'd5};
      @(negedge hclk);
      cps_en_i      = 1'b1;
      cps_disable_i = 1'b1;  // CPSID
      #5;
      if (primask_ex_o !== 1'b1) report_mismatch("primask_ex_o", 32'(primask_ex_o), 32'h1);
      if (primask_o !== 1'b0) report_mismatch("primask_o", 32'(primask_o), 32'h0);
      next_cycle();
      if (primask_o !== 1'b1) report_mismatch("primask_o", 32'(primask_o), 32'h1);
      @(negedge hclk);
      cps_en_i = 1'b1;       // CPSIE
      #5;
      if (primask_ex_o !== 1'b0) report_mismatch("primask_ex_o", 32'(primask_ex_o), 32'h0);
      next_cycle();
      if (primask_o !== 1'b0) report_mismatch("primask_o", 32'(primask_o), 32'h0);
      write_msr(psr_exc_pkg::SYSM_PRIMASK, 32'h1);
      if (primask_o !== 1'b1) report_mismatch("primask_o", 32'(primask_o), 32'h1);
      write_msr(psr_exc_pkg::SYSM_PRIMASK, 32'h0);
      if (primask_o !== 1'b0) report_mismatch("primask_o", 32'(primask_o), 32'h0);
      // SVC undefined over PRIMASK, escalate and exception number
      for (int pm = 0; pm < 2; pm++) begin
         for (int esc = 0; esc < 2; esc++) begin
            for (int k = 0; k < 5; k++) begin
               set_primask(pm[0]);
               take_exception(nums[k]);
               @(negedge hclk);
               svc_escalate_i = esc[0];
               #5;
               exp_u = (nums[k] == 6'd2) || (nums[k] == 6'd3) || pm[0] || esc[0];
               if (svc_is_undef_o !== exp_u)
                  report_mismatch("svc_is_undef_o", 32'(svc_is_undef_o), 32'(exp_u));
            end
         end
      end
   endtask

   // --------------------
   // run
   initial begin
      hclk       = 1'b0;
      hreset_n   = 1'b0;
      mismatches = 0;
      timeouts   = 0;
      lcg_state  = 32'd22457;
      idle();
      repeat (2) @(negedge hclk);
      hreset_n = 1'b1;
      test_reset();
      test_merge_flags();
      test_msr_load();
      test_cond_pass();
      test_exceptions();
      test_primask_svc();
      next_cycle();
      $display("mismatches %0d, timeouts %0d", mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* tb/psr_checker.sv */
/* mode decode assertions, bound into the status block top level
   checked on every rising hclk outside reset */
`timescale 1ns/1ns
`include "psr_params.svh"

module psr_checker (
   input logic                   hclk,
   input logic                   hreset_n,
   input logic [`PSR_IPSR_W-1:0] ipsr_o,
   input logic                   handler_o,
   input logic                   primask_o,
   input logic                   svc_escalate_i,
   input logic                   nmi_active_o,
   input logic                   hardfault_active_o,
   input logic                   svc_is_undef_o
);

   // --------------------
   // exact number decodes
   hdf_decode: assert property (@(posedge hclk) disable iff (!hreset_n)
      hardfault_active_o == (ipsr_o == psr_exc_pkg::EXC_HARDFAULT))
      else $error("hardfault_active_o disagrees with exception number");

   nmi_decode: assert property (@(posedge hclk) disable iff (!hreset_n)
      nmi_active_o == (ipsr_o == psr_exc_pkg::EXC_NMI))
      else $error("nmi_active_o disagrees with exception number");

   // --------------------
   // SVC as undefined
   svc_ok_thread: assert property (@(posedge hclk) disable iff (!hreset_n)
      (!handler_o && !primask_o && !svc_escalate_i) |-> !svc_is_undef_o)
      else $error("svc_is_undef_o set in thread mode with nothing masking");

   svc_escalated: assert property (@(posedge hclk) disable iff (!hreset_n)
      (ipsr_o == psr_exc_pkg::EXC_SVCALL && svc_escalate_i) |-> svc_is_undef_o)
      else $error("svc_is_undef_o clear for escalated SVC inside SVCall");

endmodule

bind psr_top psr_checker u_chk (
   .hclk, .hreset_n, .ipsr_o, .handler_o, .primask_o, .svc_escalate_i,
   .nmi_active_o, .hardfault_active_o, .svc_is_undef_o
);

/* rtl/psr_top.sv */
/* processor status block, plain port top level
   all strobes are one cycle and take effect only with hready_i high */
`timescale 1ns/1ns
`include "psr_params.svh"

module psr_top (
   input  logic                   hclk,
   input  logic                   hreset_n,
   input  logic                   hready_i,
   // execute results
   input  logic [`PSR_WORD_W-1:0] alu_res_i,
   input  logic [`PSR_WORD_W-1:0] shift_res_i,
   input  logic                   alu_cflag_i,
   input  logic                   alu_vflag_i,
   input  logic                   shift_nflag_i,
   input  logic                   shift_zflag_i,
   input  logic                   shift_cflag_i,
   input  logic                   shift_sel_i,
   input  logic                   nz_en_i,
   input  logic                   c_en_i,
   input  logic                   v_en_i,
   // status writes
   input  logic [`PSR_WORD_W-1:0] psr_wdata_i,       // MSR operand or popped xPSR
   input  logic                   msr_en_i,
   input  logic [1:0]             msr_sel_i,
   input  logic                   xpsr_load_i,
   input  logic [3:0]             cond_i,
   input  logic                   cps_en_i,
   input  logic                   cps_disable_i,
   // exception control
   input  logic                   int_taken_i,
   input  logic [`PSR_IPSR_W-1:0] int_num_i,
   input  logic                   exc_return_i,
   input  logic                   exc_return_psp_i,
   input  logic                   svc_escalate_i,
   output logic [`PSR_WORD_W-1:0] gpr_wdata_o,
   output logic [3:0]             apsr_o,
   output logic                   cc_pass_o,
   output logic [`PSR_IPSR_W-1:0] ipsr_o,
   output logic                   primask_o,
   output logic                   primask_ex_o,
   output logic                   control_o,
   output logic                   sp_psp_o,
   output logic                   handler_o,
   output logic                   nmi_active_o,
   output logic                   hardfault_active_o,
   output logic                   svc_is_undef_o
);

   psr_flag_if fwd_bus ();
   psr_wr_if   wr_bus ();

   // --------------------
   // write command bundle
   assign wr_bus.msr_en    = msr_en_i;
   assign wr_bus.msr_sel   = msr_sel_i;
   assign wr_bus.xpsr_load = xpsr_load_i;
   assign wr_bus.operand   = psr_wdata_i;  // decoded per command in each unit

   psr_flag_unit u_flag (
      .hclk, .hreset_n, .hready_i,
      .alu_res_i, .shift_res_i, .alu_cflag_i, .alu_vflag_i,
      .shift_nflag_i, .shift_zflag_i, .shift_cflag_i, .shift_sel_i,
      .nz_en_i, .c_en_i, .v_en_i,
      .wr (wr_bus.flag_side),
      .fwd (fwd_bus.source),
      .gpr_wdata_o, .apsr_o
   );

   psr_cond_eval u_cond (
      .fwd (fwd_bus.sink),
      .cond_i, .cc_pass_o
   );

   psr_mode_unit u_mode (
      .hclk, .hreset_n, .hready_i,
      .wr (wr_bus.mode_side),
      .cps_en_i, .cps_disable_i, .int_taken_i, .int_num_i,
      .exc_return_i, .exc_return_psp_i, .svc_escalate_i,
      .ipsr_o, .primask_o, .primask_ex_o, .control_o, .sp_psp_o,
      .handler_o, .nmi_active_o, .hardfault_active_o, .svc_is_undef_o
   );

endmodule

/* rtl/psr_mode_unit.sv */
/* exception number, PRIMASK and CONTROL[1] with mode decodes
   int_taken_i and xpsr load are never strobed together */
`timescale 1ns/1ns
`include "psr_params.svh"

module psr_mode_unit (
   input  logic                   hclk,
   input  logic                   hreset_n,
   input  logic                   hready_i,
   psr_wr_if.mode_side            wr,
   input  logic                   cps_en_i,          // CPSID/CPSIE in execute
   input  logic                   cps_disable_i,     // 1 for CPSID
   input  logic                   int_taken_i,       // exception entry done
   input  logic [`PSR_IPSR_W-1:0] int_num_i,         // new exception number
   input  logic                   exc_return_i,      // EXC_RETURN branch
   input  logic                   exc_return_psp_i,  // return to process stack
   input  logic                   svc_escalate_i,    // SVCall priority too low
   output logic [`PSR_IPSR_W-1:0] ipsr_o,
   output logic                   primask_o,
   output logic                   primask_ex_o,      // next PRIMASK
   output logic                   control_o,
   output logic                   sp_psp_o,
   output logic                   handler_o,
   output logic                   nmi_active_o,
   output logic                   hardfault_active_o,
   output logic                   svc_is_undef_o
);

   logic [`PSR_IPSR_W-1:0] ipsr_q, ipsr_nxt;
   logic                   ipsr_en;
   logic                   primask_q, primask_en, primask_nxt;
   logic                   control_q, control_en, control_nxt;
   logic                   msr_pm, msr_ctl;
   logic                   handler, nmi_active, hdf_active;
   logic                   rfi_in_irq;

   // --------------------
   // mode decodes
   assign handler    = (ipsr_q != psr_exc_pkg::EXC_THREAD);
   assign nmi_active = (ipsr_q == psr_exc_pkg::EXC_NMI);
   assign hdf_active = (ipsr_q == psr_exc_pkg::EXC_HARDFAULT);
   assign rfi_in_irq = exc_return_i & handler;  // return only counts from handler

   // exception number
   assign ipsr_en  = int_taken_i | wr.xpsr_load;
   assign ipsr_nxt = int_taken_i ? int_num_i : wr.operand.frame.ipsr;

   // --------------------
   // PRIMASK, MSR or CPS
   assign msr_pm      = wr.msr_en & (wr.msr_sel == psr_exc_pkg::SYSM_PRIMASK);
   assign primask_en  = msr_pm | cps_en_i;
   assign primask_nxt = msr_pm ? wr.operand.msr.primask : cps_disable_i;

   // CONTROL, MSR only in thread mode
   assign msr_ctl     = wr.msr_en & ~handler
                      & (wr.msr_sel == psr_exc_pkg::SYSM_CONTROL);
   assign control_en  = msr_ctl | int_taken_i | rfi_in_irq;
   assign control_nxt = ~int_taken_i
                      & (msr_ctl ? wr.operand.msr.control : exc_return_psp_i);

   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         ipsr_q    <= `PSR_IPSR_RESET;
         primask_q <= 1'b0;
         control_q <= 1'b0;
      end else if (hready_i) begin
         if (ipsr_en) begin
            ipsr_q <= ipsr_nxt;
         end
         if (primask_en) begin
            primask_q <= primask_nxt;
         end
         if (control_en) begin
            control_q <= control_nxt;  // entry always clears
         end
      end
   end

   // --------------------
   // outputs
   assign ipsr_o             = ipsr_q;
   assign primask_o          = primask_q;
   assign primask_ex_o       = primask_en ? primask_nxt : primask_q;  // CPSID sync
   assign control_o          = control_q;
   assign sp_psp_o           = control_q | (rfi_in_irq & exc_return_psp_i);
   assign handler_o          = handler;
   assign nmi_active_o       = nmi_active;
   assign hardfault_active_o = hdf_active;
   assign svc_is_undef_o     = nmi_active | hdf_active | primask_q | svc_escalate_i;

endmodule

/* rtl/psr_cond_eval.sv */
/* Bcc condition evaluation on forwarded flags
   codes 14 and 15 give no defined result */
`timescale 1ns/1ns

module psr_cond_eval (
   psr_flag_if.sink   fwd,
   input  logic [3:0] cond_i,     // Bcc condition field
   output logic       cc_pass_o
);

   logic mask_n, mask_z, mask_c, mask_v;
   logic inv_z;
   logic pass_n, pass_z, pass_c, pass_v;

   // --------------------
   // every even code reduces to
   //   ((N | mn) == (V | mv)) & ((Z ^ iz) | mz) & (C | mc)
   // odd codes take the inverse
   // masks depend on the code only, so the late flags see two gates

   assign mask_n = ( cond_i[1] & ~cond_i[3])
                 | (~cond_i[1] & ~cond_i[2]);
   assign mask_z = ( cond_i[2] & ~cond_i[3])
                 |   cond_i[1];
   assign mask_c = ( cond_i[1] &  cond_i[3])
                 | (~cond_i[1] & ~cond_i[3])
                 |   cond_i[2];
   assign mask_v = (~cond_i[1] & ~cond_i[2])
                 | (~cond_i[1] & ~cond_i[3])
                 | (~cond_i[2] & ~cond_i[3]);
   assign inv_z  = cond_i[3] | cond_i[2];  // HI and GT want Z clear

   // --------------------
   // combine with flags
   assign pass_n = mask_n | fwd.fwd_n;
   assign pass_z = mask_z | (fwd.fwd_z ^ inv_z);
   assign pass_c = mask_c | fwd.fwd_c;
   assign pass_v = mask_v | fwd.fwd_v;

   assign cc_pass_o = ((pass_n == pass_v) & pass_z & pass_c) ^ cond_i[0];

endmodule

/* rtl/psr_flag_unit.sv */
/* result merge and APSR flags
   an idle ALU or shifter must return zero, the merge is a plain OR */
`timescale 1ns/1ns
`include "psr_params.svh"

module psr_flag_unit (
   input  logic                   hclk,
   input  logic                   hreset_n,
   input  logic                   hready_i,       // core advance
   input  logic [`PSR_WORD_W-1:0] alu_res_i,
   input  logic [`PSR_WORD_W-1:0] shift_res_i,
   input  logic                   alu_cflag_i,
   input  logic                   alu_vflag_i,
   input  logic                   shift_nflag_i,
   input  logic                   shift_zflag_i,
   input  logic                   shift_cflag_i,
   input  logic                   shift_sel_i,    // take shifter flags
   input  logic                   nz_en_i,
   input  logic                   c_en_i,
   input  logic                   v_en_i,
   psr_wr_if.flag_side            wr,
   psr_flag_if.source             fwd,
   output logic [`PSR_WORD_W-1:0] gpr_wdata_o,
   output logic [3:0]             apsr_o          // {N,Z,C,V}
);

   logic [`PSR_WORD_W-1:0] res;
   logic                   n_ex, z_ex, c_ex;
   logic                   ldr_flags, msr_flags, std_flags;
   logic [3:0]             nzcv_nxt;
   logic                   nz_ena, c_ena, v_ena;
   logic [3:0]             nzcv_q;

   // --------------------
   // result merge
   assign res  = alu_res_i | shift_res_i;

   assign n_ex = shift_sel_i ? shift_nflag_i : res[`PSR_WORD_W-1];
   assign z_ex = shift_sel_i ? shift_zflag_i : ~|res;
   assign c_ex = shift_sel_i ? shift_cflag_i : alu_cflag_i;  // V always from alu

   // --------------------
   // source select, one-hot
   assign ldr_flags = wr.xpsr_load;                                     // exception return
   assign msr_flags = wr.msr_en & (wr.msr_sel == psr_exc_pkg::SYSM_APSR);
   assign std_flags = ~(ldr_flags | msr_flags);

   // frame and MSR views both hold the flags in [31:28]
   assign nzcv_nxt = std_flags ? {n_ex, z_ex, c_ex, alu_vflag_i}
                               : wr.operand.frame.nzcv;

   // load and MSR write all four flags
   assign nz_ena = hready_i & (nz_en_i | ~std_flags);
   assign c_ena  = hready_i & (c_en_i  | ~std_flags);
   assign v_ena  = hready_i & (v_en_i  | ~std_flags);

   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         nzcv_q <= `PSR_NZCV_RESET;
      end else begin
         if (nz_ena) begin
            nzcv_q[3:2] <= nzcv_nxt[3:2];
         end
         if (c_ena) begin
            nzcv_q[1] <= nzcv_nxt[1];
         end
         if (v_ena) begin
            nzcv_q[0] <= nzcv_nxt[0];
         end
      end
   end

   // --------------------
   // forward execute flags into decode
   // MSR and load values are not forwarded, the core refetches after them
   assign fwd.fwd_n = nz_en_i ? n_ex        : nzcv_q[3];
   assign fwd.fwd_z = nz_en_i ? z_ex        : nzcv_q[2];
   assign fwd.fwd_c = c_en_i  ? c_ex        : nzcv_q[1];
   assign fwd.fwd_v = v_en_i  ? alu_vflag_i : nzcv_q[0];

   assign gpr_wdata_o = res;
   assign apsr_o      = nzcv_q;

endmodule

/* rtl/psr_if.sv */
/* flag forwarding and status-write command bundles
   command signals are one-cycle strobes, qualified by hready outside */
`timescale 1ns/1ns

// forwarded flags, execute to decode
interface psr_flag_if;
   logic fwd_n;  // negative
   logic fwd_z;  // zero
   logic fwd_c;  // carry
   logic fwd_v;  // overflow

   modport source (output fwd_n, fwd_z, fwd_c, fwd_v);
   modport sink   (input  fwd_n, fwd_z, fwd_c, fwd_v);
endinterface

// status-write commands from execute
interface psr_wr_if;
   logic                    msr_en;     // MSR in execute
   logic [1:0]              msr_sel;    // SYSm select
   logic                    xpsr_load;  // xPSR pop on exception return
   psr_arch_pkg::psr_word_u operand;    // register operand word

   modport cmd (
      output msr_en, msr_sel, xpsr_load, operand
   );
   modport flag_side (
      input msr_en, msr_sel, xpsr_load, operand
   );
   modport mode_side (
      input msr_en, msr_sel, xpsr_load, operand
   );
endinterface

/* rtl/psr_exc_pkg.sv */
/* exception numbers, MSR select codes and branch condition values
   only the Bcc codes 0 to 13 are defined, AL and NV are not */
`include "psr_params.svh"

package psr_exc_pkg;

   // --------------------
   // exception numbers
   localparam logic [`PSR_IPSR_W-1:0] EXC_THREAD    = 6'd0;  // thread mode
   localparam logic [`PSR_IPSR_W-1:0] EXC_NMI       = 6'd2;
   localparam logic [`PSR_IPSR_W-1:0] EXC_HARDFAULT = 6'd3;
   localparam logic [`PSR_IPSR_W-1:0] EXC_SVCALL    = 6'd11;

   // --------------------
   // MSR special register select
   localparam logic [1:0] SYSM_APSR    = 2'd0;
   localparam logic [1:0] SYSM_PRIMASK = 2'd2;
   localparam logic [1:0] SYSM_CONTROL = 2'd3;

   // --------------------
   // Bcc condition field, odd codes invert the even ones
   localparam logic [3:0] CC_EQ = 4'd0;  localparam logic [3:0] CC_NE = 4'd1;
   localparam logic [3:0] CC_CS = 4'd2;  localparam logic [3:0] CC_CC = 4'd3;
   localparam logic [3:0] CC_MI = 4'd4;  localparam logic [3:0] CC_PL = 4'd5;
   localparam logic [3:0] CC_VS = 4'd6;  localparam logic [3:0] CC_VC = 4'd7;
   localparam logic [3:0] CC_HI = 4'd8;  localparam logic [3:0] CC_LS = 4'd9;
   localparam logic [3:0] CC_GE = 4'd10; localparam logic [3:0] CC_LT = 4'd11;
   localparam logic [3:0] CC_GT = 4'd12; localparam logic [3:0] CC_LE = 4'd13;

endpackage

/* rtl/psr_arch_pkg.sv */
/* status word layouts as seen on the register read port
   reserved bits are carried but never decoded */
`include "psr_params.svh"

package psr_arch_pkg;

   // --------------------
   // stacked xPSR, as pushed on exception entry
   typedef struct packed {
      logic [3:0]                              nzcv;  // flags in [31:28]
      logic [`PSR_WORD_W-`PSR_IPSR_W-5:0]      rsvd;  // T bit, alignment etc
      logic [`PSR_IPSR_W-1:0]                  ipsr;  // exception number
   } xpsr_frame_t;

   // --------------------
   // MSR operand word
   typedef struct packed {
      logic [3:0]                              nzcv;    // APSR flags
      logic [`PSR_WORD_W-7:0]                  rsvd;    // ignored by MSR
      logic                                    control; // CONTROL[1] in bit 1
      logic                                    primask; // PRIMASK in bit 0
   } msr_word_t;

   // one operand word, read as a frame on xPSR load
   // and as an MSR operand on MSR
   typedef union packed {
      xpsr_frame_t frame;
      msr_word_t   msr;
   } psr_word_u;

endpackage

/* rtl/psr_params.svh */
/* widths and reset values shared by the status block
   reset flags and exception number match the core's lockup-safe start */
`ifndef PSR_PARAMS_SVH
`define PSR_PARAMS_SVH

// data path width
`define PSR_WORD_W 32

// exception number width (IPSR)
`define PSR_IPSR_W 6

// start in HardFault so an early fault escalates to lockup
`define PSR_IPSR_RESET 6'd3

// N and Z set, C and V clear
`define PSR_NZCV_RESET 4'b1100

`endif
